// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_periph_fabric
RTL_TOP    := periph_fabric_top
FILELIST   := build.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
RUN_FLAGS  := +verilator+error+limit+1000
OBJ_DIR    := obj_dir
SIM_LOG    := sim.log
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(SIM_LOG)
	@grep -q "^Simulation passed$$" $(SIM_LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// ==== build.f ====
verilog/soc_pkg.sv
verilog/reset_stretch.sv
verilog/bus_cycle_fsm.sv
verilog/addr_decode.sv
verilog/gpio_regs.sv
verilog/scratch_ram.sv
verilog/periph_fabric_top.sv
tb/periph_fabric_assert.sv
tb/tb_periph_fabric.sv

// ==== tb/periph_fabric_assert.sv ====
module periph_fabric_assert (
    input logic clk_rv,
    input logic rst_rv,
    input logic sys_ready,
    input logic cyc,
    input logic stb,
    input logic latch_addr,
    input logic ack,
    input logic cpu_irq
);

    int error_count = 0; // Read by the testbench for the summary

    // --------------------------------------------------
    // Acknowledge rules
    // --------------------------------------------------
    ack_single: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        ack |=> !ack)
        else begin
            $error("ack stayed high for more than one cycle");
            error_count++;
        end

    ack_under_strobe: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        ack |-> (cyc && stb))
        else begin
            $error("ack raised without cyc and stb");
            error_count++;
        end

    // Accepted at edge 0, ack sampled high at edge 3 and not before
    ack_latency: assert property (@(posedge clk_rv) disable iff (!rst_rv || !sys_ready)
        latch_addr |-> !ack ##1 !ack ##1 !ack ##1 ack)
        else begin
            $error("ack not returned exactly 3 edges after acceptance");
            error_count++;
        end

    ack_needs_ready: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        !sys_ready |-> !ack)
        else begin
            $error("ack raised while the system is held in reset");
            error_count++;
        end

    // --------------------------------------------------
    // Interrupt
    // --------------------------------------------------
    irq_sticky: assert property (@(posedge clk_rv) disable iff (!rst_rv)
        (cpu_irq && sys_ready) |=> (cpu_irq || !sys_ready))
        else begin
            $error("cpu_irq cleared while the system is running");
            error_count++;
        end

endmodule

bind periph_fabric_top periph_fabric_assert u_fabric_assert (
    .clk_rv     (clk_rv),
    .rst_rv     (rst_rv),
    .sys_ready  (sys_ready),
    .cyc        (cyc),
    .stb        (stb),
    .latch_addr (latch_addr),
    .ack        (ack),
    .cpu_irq    (cpu_irq)
);

// ==== tb/tb_periph_fabric.sv ====
module tb_periph_fabric;
    import soc_pkg::*;

    localparam int ACK_TIMEOUT   = 50;  // Cycles to wait for one ack
    localparam int READY_TIMEOUT = 100; // Cycles to wait for reset release

    logic       clk_rv;
    logic       rst_rv;
    logic       cyc;
    logic       stb;
    logic       we;
    bus_addr_t  adr;
    bus_data_t  dat_w;
    byte_sel_t  sel;
    bus_data_t  dat_r;
    logic       ack;
    logic       init_done;
    delay_sel_t delay_sel_det;
    logic       sda_in;
    logic       led_red_n;
    logic       led_green_n;
    logic       led_blue_n;
    logic       z80_rst;
    logic       i2c_scl;
    logic       i2c_sda_oe;
    logic       usb_rst_n;
    delay_sel_t delay_sel_val;
    logic       cpu_irq;
    logic       sys_rst_n;

    bus_data_t ram_model [RAM_WORDS]; // Expected RAM contents by word index
    string     cur_test;
    int        test_errors;
    int        tests_passed;
    int        tests_failed;

    periph_fabric_top uut (.*);

    initial clk_rv = 1'b0;
    always #50 clk_rv = ~clk_rv;

    // --------------------------------------------------
    // Bookkeeping
    // --------------------------------------------------
    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("PASS %s", cur_test);
        end else begin
            tests_failed++;
            $display("Test %s finished with %0d errors", cur_test, test_errors);
        end
    endtask

    task automatic check_value(input string what, input bus_data_t expected,
                               input bus_data_t actual);
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %h, actual %h", cur_test, what, expected, actual);
            test_errors++;
        end
    endtask

    // --------------------------------------------------
    // Wishbone host
    // --------------------------------------------------
    // Called on a falling edge, returns one falling edge after the one that sees ack
    task automatic bus_cycle(input logic write, input bus_addr_t addr, input bus_data_t wdata,
                             input byte_sel_t lanes, output bus_data_t rdata);
        int waited;
        cyc    = 1'b1;
        stb    = 1'b1;
        we     = write;
        adr    = addr;
        dat_w  = wdata;
        sel    = lanes;
        waited = 0;
        do begin
            @(negedge clk_rv);
            waited++;
        end while (!ack && waited < ACK_TIMEOUT);
        rdata = dat_r;
        if (ack) begin
            @(negedge clk_rv); // Request stays on the bus until the rising edge samples ack
        end else begin
            $display("Timeout in %s: no ack for address %h within %0d cycles",
                     cur_test, addr, ACK_TIMEOUT);
            test_errors++;
        end
    endtask

    task automatic bus_release();
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    function automatic bus_addr_t random_ram_addr();
        return RAM_BASE | ($urandom & 32'h0000_FFFC); // Anywhere in the 64 KiB window
    endfunction

    function automatic bus_addr_t gpio_addr(input gpio_index_t index);
        return GPIO_BASE | bus_addr_t'({index, 2'b00});
    endfunction

    task automatic ram_write(input bus_addr_t addr, input bus_data_t data, input byte_sel_t lanes);
        bus_data_t ignored;
        bus_cycle(1'b1, addr, data, lanes, ignored);
        for (int lane = 0; lane < 4; lane++) begin
            if (lanes[lane]) begin
                ram_model[addr[9:2]][lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
    endtask

    task automatic ram_read_check(input bus_addr_t addr);
        bus_data_t rdata;
        bus_cycle(1'b0, addr, '0, 4'hF, rdata);
        check_value($sformatf("ram read %h", addr), ram_model[addr[9:2]], rdata);
    endtask

    task automatic gpio_write(input gpio_index_t index, input bus_data_t data);
        bus_data_t ignored;
        bus_cycle(1'b1, gpio_addr(index), data, 4'hF, ignored);
    endtask

    task automatic gpio_read_check(input gpio_index_t index, input bus_data_t expected);
        bus_data_t rdata;
        bus_cycle(1'b0, gpio_addr(index), '0, 4'hF, rdata);
        check_value($sformatf("gpio read index %0d", index), expected, rdata);
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        bus_addr_t  written [8];
        bus_addr_t  addr;
        bus_data_t  rdata;
        bus_data_t  word;
        logic [2:0] leds;
        int         cycles;
        int         assert_errors;
        void'($urandom(25731));
        rst_rv        = 1'b0;
        cyc           = 1'b0;
        stb           = 1'b0;
        we            = 1'b0;
        adr           = '0;
        dat_w         = '0;
        sel           = '0;
        init_done     = 1'b0;
        delay_sel_det = delay_sel_t'($urandom);
        sda_in        = 1'b1;
        tests_passed  = 0;
        tests_failed  = 0;
        repeat (10) @(negedge clk_rv);
        rst_rv = 1'b1;

        // Request waits while the memory controller is still initialising
        start_test("reset_release");
        repeat (4) begin
            @(negedge clk_rv);
            check_value("sys_rst_n before init_done", 0, sys_rst_n);
        end
        cyc       = 1'b1;
        stb       = 1'b1;
        adr       = gpio_addr(GPIO_DELAY_SEL);
        sel       = 4'hF;
        init_done = 1'b1;
        cycles    = 0;
        do begin
            @(negedge clk_rv);
            cycles++;
            if (ack) begin
                $display("Ack returned before reset release in %s", cur_test);
                test_errors++;
            end
        end while (!sys_rst_n && cycles < READY_TIMEOUT);
        check_value("cycles to release", RESET_HOLD_CYCLES, cycles);
        bus_cycle(1'b0, gpio_addr(GPIO_DELAY_SEL), '0, 4'hF, rdata); // Same request, still held
        check_value("held request data", bus_data_t'(delay_sel_det), rdata);
        bus_release();
        finish_test();

        start_test("scratch_ram");
        for (int i = 0; i < 8; i++) begin
            written[i] = random_ram_addr();
            ram_write(written[i], $urandom, 4'hF);
        end
        for (int i = 0; i < 8; i++) begin
            ram_read_check(written[i]);
        end
        for (int i = 0; i < 4; i++) begin
            ram_write(written[0], $urandom, byte_sel_t'($urandom)); // Partial lanes
            ram_read_check(written[0]);
        end
        for (int i = 0; i < 8; i++) begin
            addr = written[i];
            ram_read_check({addr[31:16], addr[15:10] + 6'd1, addr[9:0]}); // 1 KiB echo
        end
        check_value("cpu_irq after ram", 0, cpu_irq);
        bus_release();
        finish_test();

        start_test("gpio_regs");
        gpio_read_check(GPIO_DELAY_SEL, bus_data_t'(delay_sel_det));
        check_value("delay_sel_val", bus_data_t'(delay_sel_det), bus_data_t'(delay_sel_val));
        check_value("z80_rst pin", 1, z80_rst);
        check_value("led pins after reset", 3'b111, {led_blue_n, led_green_n, led_red_n});
        check_value("i2c_scl after reset", 1, i2c_scl);
        check_value("usb_rst_n after reset", 0, usb_rst_n);
        gpio_read_check(GPIO_Z80_RST, 1);
        leds      = 3'($urandom);
        word      = $urandom;
        word[2:0] = leds;
        gpio_write(GPIO_LEDS, word);
        gpio_read_check(GPIO_LEDS, bus_data_t'(leds));
        check_value("led pins", bus_data_t'(leds ^ 3'b111), {led_blue_n, led_green_n, led_red_n});
        word = $urandom;
        gpio_write(GPIO_DELAY_SEL, word);
        check_value("delay_sel_val written", bus_data_t'(word[4:0]), bus_data_t'(delay_sel_val));
        gpio_write(GPIO_I2C_SCL, 32'h0);
        check_value("i2c_scl", 0, i2c_scl);
        gpio_write(GPIO_USB_RST, 32'h1);
        check_value("usb_rst_n", 1, usb_rst_n);
        gpio_write(GPIO_I2C_SDA, 32'h0);
        check_value("i2c_sda_oe", 1, i2c_sda_oe);
        for (int i = 0; i < 2; i++) begin
            sda_in = i[0];
            gpio_read_check(GPIO_I2C_SDA, bus_data_t'(sda_in));
        end
        gpio_read_check(4'd2, 0); // Unused index
        check_value("cpu_irq after gpio", 0, cpu_irq);
        bus_release();
        finish_test();

        start_test("unmapped");
        check_value("cpu_irq before unmapped", 0, cpu_irq);
        addr = 32'h4000_0000 | ($urandom & 32'h3FFF_FFFC); // Between the two windows
        bus_cycle(1'b0, addr, '0, 4'hF, rdata);
        check_value("unmapped read", 32'hFFFF_FFFF, rdata);
        check_value("cpu_irq after unmapped", 1, cpu_irq);
        ram_read_check(written[1]);
        gpio_read_check(GPIO_Z80_RST, 1);
        check_value("cpu_irq after mapped", 1, cpu_irq);
        bus_release();
        finish_test();

        // No idle cycle between requests
        start_test("back_to_back");
        for (int i = 0; i < 24; i++) begin
            case ($urandom % 3)
                0:       ram_write(written[$urandom % 8], $urandom, byte_sel_t'($urandom));
                1:       ram_read_check(written[$urandom % 8]);
                default: gpio_read_check(GPIO_DELAY_SEL, bus_data_t'(delay_sel_det));
            endcase
        end
        bus_release();
        finish_test();

        repeat (4) @(negedge clk_rv); // Let pending assertion attempts finish
        assert_errors = uut.u_fabric_assert.error_count;
        $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, assert_errors);
        if (tests_failed == 0 && assert_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog/addr_decode.sv ====
module addr_decode import soc_pkg::*; (
    input  logic        clk_rv,
    input  logic        rst_rv,
    input  logic        latch_addr,
    input  bus_addr_t   adr,
    input  bus_data_t   ram_rdata,
    input  bus_data_t   gpio_rdata,
    output region_t     region,
    output gpio_index_t gpio_index,
    output ram_index_t  ram_index,
    output bus_data_t   dat_r
);

    logic in_ram;
    logic in_gpio;

    // --------------------------------------------------
    // Window compare
    // --------------------------------------------------
    assign in_ram  = (adr >= RAM_BASE);                         // Up to the top of memory
    assign in_gpio = (adr >= GPIO_BASE) && (adr < GPIO_LIMIT);

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            region <= REGION_NONE;
        end else if (latch_addr) begin
            if (in_ram) begin
                region <= REGION_RAM;
            end else if (in_gpio) begin
                region <= REGION_GPIO;
            end else begin
                region <= REGION_NONE; // Raises the bus-error interrupt
            end
        end
    end

    // Word indices inside the windows
    always_ff @(posedge clk_rv) begin
        if (latch_addr) begin
            gpio_index <= adr[5:2];
            ram_index  <= adr[9:2]; // Higher bits ignored, so the RAM echoes every 1 KiB
        end
    end

    // --------------------------------------------------
    // Read data return
    // --------------------------------------------------
    always_comb begin
        case (region)
            REGION_RAM:  dat_r = ram_rdata;
            REGION_GPIO: dat_r = gpio_rdata;
            default:     dat_r = UNMAPPED_DATA;
        endcase
    end

endmodule

// ==== verilog/bus_cycle_fsm.sv ====
module bus_cycle_fsm import soc_pkg::*; (
    input  logic    clk_rv,
    input  logic    rst_rv,
    input  logic    sys_ready,
    input  logic    cyc,
    input  logic    stb,
    input  region_t region,
    output logic    latch_addr,
    output logic    access_en,
    output logic    ack,
    output logic    cpu_irq
);

    bus_state_t state;
    bus_state_t state_next;
    logic       request;
    logic       irq_pending;

    assign request = cyc && stb && sys_ready;

    // --------------------------------------------------
    // Cycle sequencing
    // --------------------------------------------------
    always_ff @(posedge clk_rv) begin
        if (!rst_rv || !sys_ready) begin
            state <= BUS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Once accepted, a cycle always runs to completion
    always_comb begin
        state_next = state;
        case (state)
            BUS_IDLE: begin
                if (request) begin
                    state_next = BUS_DECODE;
                end
            end
            BUS_DECODE: state_next = BUS_ACCESS; // Region is valid here
            BUS_ACCESS: state_next = BUS_ACK;    // Targets write or load read data
            BUS_ACK:    state_next = BUS_IDLE;
            default:    state_next = BUS_IDLE;
        endcase
    end

    assign latch_addr = (state == BUS_IDLE) && request;
    assign access_en  = (state == BUS_ACCESS);

    // sys_ready is registered upstream, so a cycle may reach BUS_ACK just as it drops
    assign ack = (state == BUS_ACK) && sys_ready;

    // --------------------------------------------------
    // Sticky bus-error interrupt
    // --------------------------------------------------
    always_ff @(posedge clk_rv) begin
        if (!rst_rv || !sys_ready) begin
            irq_pending <= 1'b0;
        end else if ((state == BUS_DECODE) && (region == REGION_NONE)) begin
            irq_pending <= 1'b1; // Unmapped address
        end
    end

    assign cpu_irq = irq_pending && sys_ready;

endmodule

// ==== verilog/gpio_regs.sv ====
module gpio_regs import soc_pkg::*; (
    input  logic        clk_rv,
    input  logic        rst_rv,
    input  logic        sys_ready,
    input  logic        access_en,
    input  logic        we,
    input  region_t     region,
    input  gpio_index_t gpio_index,
    input  bus_data_t   dat_w,
    input  delay_sel_t  delay_sel_det,
    input  logic        sda_in,
    output bus_data_t   gpio_rdata,
    output delay_sel_t  delay_sel_val,
    output logic        led_red_n,
    output logic        led_green_n,
    output logic        led_blue_n,
    output logic        z80_rst,
    output logic        i2c_scl,
    output logic        i2c_sda_oe,
    output logic        usb_rst_n
);

    logic led_red;
    logic led_green;
    logic led_blue;
    logic sda_reg;
    logic gpio_sel;

    assign gpio_sel = access_en && (region == REGION_GPIO);

    // --------------------------------------------------
    // Control registers
    // --------------------------------------------------
    always_ff @(posedge clk_rv) begin
        if (!rst_rv || !sys_ready) begin
            delay_sel_val <= delay_sel_det; // Follow detection until the system runs
            led_red       <= 1'b0;
            led_green     <= 1'b0;
            led_blue      <= 1'b0;
            z80_rst       <= 1'b1;          // Z80 held in reset
            i2c_scl       <= 1'b1;
            sda_reg       <= 1'b1;          // Bus released
            usb_rst_n     <= 1'b0;
        end else if (gpio_sel && we) begin
            case (gpio_index)
                GPIO_DELAY_SEL: delay_sel_val <= dat_w[4:0];
                GPIO_LEDS: begin
                    led_red   <= dat_w[0];
                    led_green <= dat_w[1];
                    led_blue  <= dat_w[2];
                end
                GPIO_Z80_RST: z80_rst   <= dat_w[0];
                GPIO_I2C_SCL: i2c_scl   <= dat_w[0];
                GPIO_I2C_SDA: sda_reg   <= dat_w[0];
                GPIO_USB_RST: usb_rst_n <= dat_w[0];
                default: ;                  // Unused indices drop writes
            endcase
        end
    end

    // Status read, loaded at the end of the access state
    always_ff @(posedge clk_rv) begin
        if (gpio_sel && !we) begin
            case (gpio_index)
                GPIO_DELAY_SEL: gpio_rdata <= {27'd0, delay_sel_det};
                GPIO_LEDS:      gpio_rdata <= {29'd0, led_blue, led_green, led_red};
                GPIO_Z80_RST:   gpio_rdata <= {31'd0, z80_rst};
                GPIO_I2C_SDA:   gpio_rdata <= {31'd0, sda_in};  // Live pin level
                default:        gpio_rdata <= '0;
            endcase
        end
    end

    // --------------------------------------------------
    // Pin drive
    // --------------------------------------------------
    assign led_red_n   = ~led_red;   // LEDs are active low
    assign led_green_n = ~led_green;
    assign led_blue_n  = ~led_blue;
    assign i2c_sda_oe  = ~sda_reg;   // Open drain, pull low when the register is 0

endmodule

// ==== verilog/periph_fabric_top.sv ====
module periph_fabric_top import soc_pkg::*; (
    input  logic       clk_rv,
    input  logic       rst_rv,

    // Wishbone classic slave
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  bus_addr_t  adr,
    input  bus_data_t  dat_w,
    input  byte_sel_t  sel,
    output bus_data_t  dat_r,
    output logic       ack,

    // Memory controller status
    input  logic       init_done,
    input  delay_sel_t delay_sel_det,

    // Pins
    input  logic       sda_in,
    output logic       led_red_n,
    output logic       led_green_n,
    output logic       led_blue_n,
    output logic       z80_rst,
    output logic       i2c_scl,
    output logic       i2c_sda_oe,
    output logic       usb_rst_n,
    output delay_sel_t delay_sel_val,

    output logic       cpu_irq,
    output logic       sys_rst_n
);

    logic        sys_ready;
    logic        latch_addr;
    logic        access_en;
    region_t     region;
    gpio_index_t gpio_index;
    ram_index_t  ram_index;
    bus_data_t   ram_rdata;
    bus_data_t   gpio_rdata;

    // --------------------------------------------------
    // Reset and bus control
    // --------------------------------------------------
    reset_stretch u_reset_stretch (
        .clk_rv    (clk_rv),
        .rst_rv    (rst_rv),
        .init_done (init_done),
        .sys_ready (sys_ready)
    );

    assign sys_rst_n = sys_ready; // Active-low reset for the rest of the system

    bus_cycle_fsm u_bus_cycle_fsm (
        .clk_rv     (clk_rv),
        .rst_rv     (rst_rv),
        .sys_ready  (sys_ready),
        .cyc        (cyc),
        .stb        (stb),
        .region     (region),
        .latch_addr (latch_addr),
        .access_en  (access_en),
        .ack        (ack),
        .cpu_irq    (cpu_irq)
    );

    addr_decode u_addr_decode (
        .clk_rv     (clk_rv),
        .rst_rv     (rst_rv),
        .latch_addr (latch_addr),
        .adr        (adr),
        .ram_rdata  (ram_rdata),
        .gpio_rdata (gpio_rdata),
        .region     (region),
        .gpio_index (gpio_index),
        .ram_index  (ram_index),
        .dat_r      (dat_r)
    );

    // --------------------------------------------------
    // Targets
    // --------------------------------------------------
    gpio_regs u_gpio_regs (
        .clk_rv        (clk_rv),
        .rst_rv        (rst_rv),
        .sys_ready     (sys_ready),
        .access_en     (access_en),
        .we            (we),
        .region        (region),
        .gpio_index    (gpio_index),
        .dat_w         (dat_w),
        .delay_sel_det (delay_sel_det),
        .sda_in        (sda_in),
        .gpio_rdata    (gpio_rdata),
        .delay_sel_val (delay_sel_val),
        .led_red_n     (led_red_n),
        .led_green_n   (led_green_n),
        .led_blue_n    (led_blue_n),
        .z80_rst       (z80_rst),
        .i2c_scl       (i2c_scl),
        .i2c_sda_oe    (i2c_sda_oe),
        .usb_rst_n     (usb_rst_n)
    );

    scratch_ram u_scratch_ram (
        .clk_rv    (clk_rv),
        .access_en (access_en),
        .we        (we),
        .region    (region),
        .ram_index (ram_index),
        .sel       (sel),
        .dat_w     (dat_w),
        .ram_rdata (ram_rdata)
    );

endmodule

// ==== verilog/reset_stretch.sv ====
module reset_stretch import soc_pkg::*; (
    input  logic clk_rv,
    input  logic rst_rv,
    input  logic init_done,
    output logic sys_ready
);

    localparam int COUNT_W = $clog2(RESET_HOLD_CYCLES + 1);

    logic [COUNT_W-1:0] hold_count;

    // Counts edges with init_done high and saturates at the hold length
    always_ff @(posedge clk_rv) begin
        if (!rst_rv || !init_done) begin
            hold_count <= '0; // Memory controller not ready, start over
        end else if (hold_count != COUNT_W'(RESET_HOLD_CYCLES)) begin
            hold_count <= hold_count + 1'b1;
        end
    end

    // Released on the 16th edge that sees init_done, dropped one edge after it falls
    assign sys_ready = (hold_count == COUNT_W'(RESET_HOLD_CYCLES));

endmodule

// ==== verilog/scratch_ram.sv ====
module scratch_ram import soc_pkg::*; (
    input  logic       clk_rv,
    input  logic       access_en,
    input  logic       we,
    input  region_t    region,
    input  ram_index_t ram_index,
    input  byte_sel_t  sel,
    input  bus_data_t  dat_w,
    output bus_data_t  ram_rdata
);

    localparam int LANES = $bits(byte_sel_t);

    bus_data_t mem [RAM_WORDS];
    logic      ram_sel;

    assign ram_sel = access_en && (region == REGION_RAM);

    always_ff @(posedge clk_rv) begin
        if (ram_sel) begin
            if (we) begin
                // Only the lanes flagged in sel are written
                for (int lane = 0; lane < LANES; lane++) begin
                    if (sel[lane]) begin
                        mem[ram_index][lane*8 +: 8] <= dat_w[lane*8 +: 8];
                    end
                end
            end else begin
                ram_rdata <= mem[ram_index]; // Whole word regardless of sel
            end
        end
    end

endmodule

// ==== verilog/soc_pkg.sv ====
package soc_pkg;

    // --------------------------------------------------
    // Bus and register widths
    // --------------------------------------------------
    typedef logic [31:0] bus_addr_t;   // Byte address
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0]  byte_sel_t;   // One bit per byte lane
    typedef logic [7:0]  ram_index_t;  // Scratch RAM word index
    typedef logic [3:0]  gpio_index_t; // From address bits 5:2
    typedef logic [4:0]  delay_sel_t;  // DDR read delay select

    // Decoded target of the current bus cycle
    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_RAM,
        REGION_GPIO
    } region_t;

    // One Wishbone cycle walks through all four states in order
    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_DECODE,
        BUS_ACCESS,
        BUS_ACK
    } bus_state_t;

    // --------------------------------------------------
    // Memory map
    // --------------------------------------------------
    // Scratch RAM runs to the top of the address space and repeats every 1 KiB
    localparam bus_addr_t RAM_BASE  = 32'hFFFF_0000;
    localparam int        RAM_WORDS = 256;

    localparam bus_addr_t GPIO_BASE  = 32'h0300_0000; // Inclusive
    localparam bus_addr_t GPIO_LIMIT = 32'h0300_0100; // Exclusive

    localparam bus_data_t UNMAPPED_DATA = 32'hFFFF_FFFF;

    // Cycles of reset held after the memory controller is ready
    localparam int RESET_HOLD_CYCLES = 16;

    // GPIO register indices
    localparam gpio_index_t GPIO_DELAY_SEL = 4'd0;
    localparam gpio_index_t GPIO_LEDS      = 4'd1;
    localparam gpio_index_t GPIO_Z80_RST   = 4'd3;
    localparam gpio_index_t GPIO_I2C_SCL   = 4'd5;
    localparam gpio_index_t GPIO_I2C_SDA   = 4'd6;
    localparam gpio_index_t GPIO_USB_RST   = 4'd7;

endpackage
